/* cpu_params.svh */
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Bus, register and register file sizes.
`define DATA_WIDTH 32
`define NUM_REGS   16

// Instruction word fields.
`define OPC_MSB 31
`define OPC_LSB 27
`define RA_MSB  26
`define RA_LSB  23
`define RB_MSB  22
`define RB_LSB  19
`define RC_MSB  18
`define RC_LSB  15

`endif

/* cpuPkg.sv */
`include "cpu_params.svh"

package cpuPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction and ALU encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Opcodes not listed here only fetch.
    typedef enum logic [4:0] {
        opLd   = 5'b00000,
        opAdd  = 5'b00011,
        opSub  = 5'b00100,
        opAnd  = 5'b00101,
        opOr   = 5'b00110,
        opRor  = 5'b00111,
        opRol  = 5'b01000,
        opShr  = 5'b01001,
        opShl  = 5'b01011,
        opMul  = 5'b01111,
        opMfhi = 5'b11000,
        opMflo = 5'b11001
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluShr,
        aluShl,
        aluRor,
        aluRol,
        aluMul,
        aluPassB
    } aluOpT;

    // Which block drives the shared bus.
    typedef enum logic [2:0] {
        srcNone,
        srcPc,
        srcMdr,
        srcReg,
        srcZlo,
        srcZhi,
        srcHi,
        srcLo
    } busSrcT;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer and control word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [3:0] {
        stIdle,
        stT0,
        stT1,
        stT2,
        stT3,
        stT4,
        stT5,
        stT6
    } stepT;

    typedef struct packed {
        busSrcT      busSrc;
        logic [3:0]  regSel;
        logic        regIn;
        logic        marIn;
        logic        mdrIn;
        logic        memRead;
        logic        pcIn;
        logic        incPc;
        logic        irIn;
        logic        yIn;
        logic        zIn;
        logic        hiIn;
        logic        loIn;
        aluOpT       aluOp;
    } ctrlWordT;

    // Register write, as seen from outside.
    typedef struct packed {
        logic                   valid;
        logic [3:0]             index;
        logic [`DATA_WIDTH-1:0] data;
    } wbT;

endpackage

/* regFile.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"

module regFile import cpuPkg::*; (
    input  logic                   Clock,
    input  logic                   arstN,
    input  ctrlWordT               ctrl,
    input  logic [`DATA_WIDTH-1:0] bus,
    output logic [`DATA_WIDTH-1:0] readData,
    output wbT                     wb
);

    logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regIn) begin
            regs[ctrl.regSel] <= bus;
        end
    end

    // One select serves both the read port and the write.
    assign readData = regs[ctrl.regSel];

    // Mirror of the write above.
    assign wb.valid = ctrl.regIn;
    assign wb.index = ctrl.regSel;
    assign wb.data  = bus;

endmodule

/* aluUnit.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"

module aluUnit import cpuPkg::*; (
    input  logic                   Clock,
    input  logic                   arstN,
    input  ctrlWordT               ctrl,
    input  logic [`DATA_WIDTH-1:0] bus,
    output logic [`DATA_WIDTH-1:0] zLo,
    output logic [`DATA_WIDTH-1:0] zHi,
    output logic [`DATA_WIDTH-1:0] hi,
    output logic [`DATA_WIDTH-1:0] lo
);

    localparam int ShiftW = $clog2(`DATA_WIDTH);

    logic [`DATA_WIDTH-1:0]   y;
    logic [2*`DATA_WIDTH-1:0] z;
    logic [2*`DATA_WIDTH-1:0] aluResult;
    logic [2*`DATA_WIDTH-1:0] rorWide;
    logic [2*`DATA_WIDTH-1:0] rolWide;
    logic [ShiftW-1:0]        shAmt;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Operation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign shAmt = bus[ShiftW-1:0];

    // Rotates come from shifting two copies of Y side by side.
    assign rorWide = {y, y} >> shAmt;
    assign rolWide = {y, y} << shAmt;

    always_comb begin
        aluResult = '0;
        case (ctrl.aluOp)
            aluAdd:  aluResult[`DATA_WIDTH-1:0] = y + bus;
            aluSub:  aluResult[`DATA_WIDTH-1:0] = y - bus;
            aluAnd:  aluResult[`DATA_WIDTH-1:0] = y & bus;
            aluOr:   aluResult[`DATA_WIDTH-1:0] = y | bus;
            aluShr:  aluResult[`DATA_WIDTH-1:0] = y >> shAmt;
            aluShl:  aluResult[`DATA_WIDTH-1:0] = y << shAmt;
            aluRor:  aluResult[`DATA_WIDTH-1:0] = rorWide[`DATA_WIDTH-1:0];
            aluRol:  aluResult[`DATA_WIDTH-1:0] = rolWide[2*`DATA_WIDTH-1:`DATA_WIDTH];
            // Signed product, full width.
            aluMul:  aluResult = (2*`DATA_WIDTH)'($signed(y)) *
                                 (2*`DATA_WIDTH)'($signed(bus));
            default: aluResult[`DATA_WIDTH-1:0] = bus;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Registers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge Clock) begin
        if (ctrl.yIn) begin
            y <= bus;
        end
        if (ctrl.zIn) begin
            z <= aluResult;
        end
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            hi <= '0;
            lo <= '0;
        end else begin
            if (ctrl.hiIn) begin
                hi <= bus;
            end
            if (ctrl.loIn) begin
                lo <= bus;
            end
        end
    end

    assign zLo = z[`DATA_WIDTH-1:0];
    assign zHi = z[2*`DATA_WIDTH-1:`DATA_WIDTH];

endmodule

/* memInterface.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"

module memInterface import cpuPkg::*; (
    input  logic                   Clock,
    input  logic                   arstN,
    input  ctrlWordT               ctrl,
    input  logic [`DATA_WIDTH-1:0] bus,
    input  logic [`DATA_WIDTH-1:0] memData,
    output logic [`DATA_WIDTH-1:0] mdr,
    output logic [`DATA_WIDTH-1:0] mar
);

    logic [`DATA_WIDTH-1:0] mdrNext;

    // A read takes the memory word, otherwise the bus.
    assign mdrNext = ctrl.memRead ? memData : bus;

    always_ff @(posedge Clock) begin
        if (ctrl.mdrIn) begin
            mdr <= mdrNext;
        end
    end

    // MAR drives the external address.
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            mar <= '0;
        end else if (ctrl.marIn) begin
            mar <= bus;
        end
    end

endmodule

/* pcUnit.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"

module pcUnit import cpuPkg::*; (
    input  logic                   Clock,
    input  logic                   arstN,
    input  ctrlWordT               ctrl,
    input  logic [`DATA_WIDTH-1:0] bus,
    output logic [`DATA_WIDTH-1:0] pc,
    output opcodeT                 opcode,
    output logic [3:0]             ra,
    output logic [3:0]             rb,
    output logic [3:0]             rc
);

    logic [`DATA_WIDTH-1:0] ir;

    // A bus load takes priority over the increment.
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            pc <= '0;
        end else if (ctrl.pcIn) begin
            pc <= bus;
        end else if (ctrl.incPc) begin
            pc <= pc + `DATA_WIDTH'(1);
        end
    end

    // Instruction register, loaded from the bus.
    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            ir <= '0;
        end else if (ctrl.irIn) begin
            ir <= bus;
        end
    end

    // Field split.
    assign opcode = opcodeT'(ir[`OPC_MSB:`OPC_LSB]);
    assign ra     = ir[`RA_MSB:`RA_LSB];
    assign rb     = ir[`RB_MSB:`RB_LSB];
    assign rc     = ir[`RC_MSB:`RC_LSB];

endmodule

/* controlSequencer.sv */
`timescale 1ns/1ns

module controlSequencer import cpuPkg::*; (
    input  logic       Clock,
    input  logic       arstN,
    input  logic       start,
    input  opcodeT     opcode,
    input  logic [3:0] ra,
    input  logic [3:0] rb,
    input  logic [3:0] rc,
    output ctrlWordT   ctrl,
    output logic       busy,
    output logic       done
);

    stepT  step;
    stepT  stepNext;
    aluOpT aluSel;
    logic  isLd;
    logic  isMul;
    logic  isMove;
    logic  isAlu;
    logic  lastStep;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcode decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        case (opcode)
            opAdd:   aluSel = aluAdd;
            opSub:   aluSel = aluSub;
            opAnd:   aluSel = aluAnd;
            opOr:    aluSel = aluOr;
            opShr:   aluSel = aluShr;
            opShl:   aluSel = aluShl;
            opRor:   aluSel = aluRor;
            opRol:   aluSel = aluRol;
            opMul:   aluSel = aluMul;
            default: aluSel = aluPassB;
        endcase
    end

    assign isLd   = (opcode == opLd);
    assign isMul  = (opcode == opMul);
    assign isMove = (opcode == opMfhi) || (opcode == opMflo);
    assign isAlu  = (aluSel != aluPassB) && !isMul;

    // Final step per class. The IR is only valid from T3, so unknown opcodes stop there.
    always_comb begin
        case (step)
            stT3:    lastStep = !(isLd || isAlu || isMul);
            stT4:    lastStep = isLd;
            stT5:    lastStep = isAlu;
            stT6:    lastStep = 1'b1;
            default: lastStep = 1'b0;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Step FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        stepNext = step;
        case (step)
            stIdle: begin
                if (start) begin
                    stepNext = stT0;
                end
            end
            stT0:    stepNext = stT1;
            stT1:    stepNext = stT2;
            default: stepNext = lastStep ? stIdle : stepT'(step + 4'd1);
        endcase
    end

    always_ff @(posedge Clock or negedge arstN) begin
        if (!arstN) begin
            step <= stIdle;
        end else begin
            step <= stepNext;
        end
    end

    assign busy = (step != stIdle);
    assign done = lastStep;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control word
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        ctrl        = '0;
        ctrl.busSrc = srcNone;
        ctrl.aluOp  = aluPassB;
        case (step)
            stT0: begin
                ctrl.busSrc = srcPc;
                ctrl.marIn  = 1'b1;
                ctrl.incPc  = 1'b1;
            end
            stT1: begin
                ctrl.memRead = 1'b1;
                ctrl.mdrIn   = 1'b1;
            end
            stT2: begin
                ctrl.busSrc = srcMdr;
                ctrl.irIn   = 1'b1;
            end
            stT3: begin
                if (isLd) begin
                    ctrl.memRead = 1'b1;
                    ctrl.mdrIn   = 1'b1;
                end else if (isMove) begin
                    ctrl.busSrc = (opcode == opMfhi) ? srcHi : srcLo;
                    ctrl.regSel = ra;
                    ctrl.regIn  = 1'b1;
                end else begin
                    ctrl.busSrc = srcReg;
                    ctrl.regSel = rb;
                    ctrl.yIn    = 1'b1;
                end
            end
            stT4: begin
                if (isLd) begin
                    ctrl.busSrc = srcMdr;
                    ctrl.regSel = ra;
                    ctrl.regIn  = 1'b1;
                end else begin
                    ctrl.busSrc = srcReg;
                    ctrl.regSel = rc;
                    ctrl.zIn    = 1'b1;
                    ctrl.aluOp  = aluSel;
                end
            end
            stT5: begin
                ctrl.busSrc = srcZlo;
                if (isMul) begin
                    ctrl.loIn = 1'b1;
                end else begin
                    ctrl.regSel = ra;
                    ctrl.regIn  = 1'b1;
                end
            end
            stT6: begin
                ctrl.busSrc = srcZhi;
                ctrl.hiIn   = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

/* cpuDatapath.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpuDatapath import cpuPkg::*; (
    input  logic                   Clock,
    input  logic                   arstN,
    input  logic                   start,
    input  logic [`DATA_WIDTH-1:0] memData,
    output logic                   busy,
    output logic                   done,
    output logic [`DATA_WIDTH-1:0] memAddr,
    output wbT                     wb
);

    ctrlWordT               ctrl;
    opcodeT                 opcode;
    logic [3:0]             ra;
    logic [3:0]             rb;
    logic [3:0]             rc;
    logic [`DATA_WIDTH-1:0] bus;
    logic [`DATA_WIDTH-1:0] readData;
    logic [`DATA_WIDTH-1:0] zLo;
    logic [`DATA_WIDTH-1:0] zHi;
    logic [`DATA_WIDTH-1:0] hi;
    logic [`DATA_WIDTH-1:0] lo;
    logic [`DATA_WIDTH-1:0] mdr;
    logic [`DATA_WIDTH-1:0] pc;

    // Shared bus, one driver per cycle.
    always_comb begin
        case (ctrl.busSrc)
            srcPc:   bus = pc;
            srcMdr:  bus = mdr;
            srcReg:  bus = readData;
            srcZlo:  bus = zLo;
            srcZhi:  bus = zHi;
            srcHi:   bus = hi;
            srcLo:   bus = lo;
            default: bus = '0;
        endcase
    end

    controlSequencer controlSequencer_inst (
        .Clock  (Clock),
        .arstN  (arstN),
        .start  (start),
        .opcode (opcode),
        .ra     (ra),
        .rb     (rb),
        .rc     (rc),
        .ctrl   (ctrl),
        .busy   (busy),
        .done   (done)
    );

    regFile regFile_inst (
        .Clock    (Clock),
        .arstN    (arstN),
        .ctrl     (ctrl),
        .bus      (bus),
        .readData (readData),
        .wb       (wb)
    );

    aluUnit aluUnit_inst (
        .Clock (Clock),
        .arstN (arstN),
        .ctrl  (ctrl),
        .bus   (bus),
        .zLo   (zLo),
        .zHi   (zHi),
        .hi    (hi),
        .lo    (lo)
    );

    memInterface memInterface_inst (
        .Clock   (Clock),
        .arstN   (arstN),
        .ctrl    (ctrl),
        .bus     (bus),
        .memData (memData),
        .mdr     (mdr),
        .mar     (memAddr)
    );

    pcUnit pcUnit_inst (
        .Clock  (Clock),
        .arstN  (arstN),
        .ctrl   (ctrl),
        .bus    (bus),
        .pc     (pc),
        .opcode (opcode),
        .ra     (ra),
        .rb     (rb),
        .rc     (rc)
    );

endmodule

/* cpuTb.sv */
`timescale 1ns/1ns
`include "cpu_params.svh"

module cpuTb import cpuPkg::*; ();

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] instr;
        logic [`DATA_WIDTH-1:0] data;
        logic [7:0]             gap;
        logic                   extraStart;
        logic [3:0]             expLatency;
        wbT                     expWb;
    } stimRowT;

    logic                   Clock;
    logic                   arstN;
    logic                   start;
    logic [`DATA_WIDTH-1:0] memData;
    logic                   busy;
    logic                   done;
    logic [`DATA_WIDTH-1:0] memAddr;
    wbT                     wb;

    stimRowT                stimTable[$];
    logic [`DATA_WIDTH-1:0] modelRegs [`NUM_REGS];
    logic [`DATA_WIDTH-1:0] modelHi;
    logic [`DATA_WIDTH-1:0] modelLo;
    logic [`DATA_WIDTH-1:0] modelPc;
    logic [31:0]            lfsrState = 32'h72dc2e75;
    int                     errors = 0;
    int                     testsRun = 0;
    int                     testsFailed = 0;
    int                     cycleCount = 0;
    int                     timeoutLimit = 10000;

    cpuDatapath cpuDatapath_inst (
        .Clock   (Clock),
        .arstN   (arstN),
        .start   (start),
        .memData (memData),
        .busy    (busy),
        .done    (done),
        .memAddr (memAddr),
        .wb      (wb)
    );

    initial begin
        Clock = 1'b0;
        forever #20 Clock = ~Clock;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Random source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic takeBits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrNext(lfsrState);
            val = {val[30:0], lfsrState[0]};
        end
    endtask

    // Rotations one bit at a time.
    function automatic logic [31:0] rotRight(input logic [31:0] x, input logic [4:0] n);
        logic [31:0] r;
        r = x;
        for (int k = 0; k < int'(n); k++) begin
            r = {r[0], r[31:1]};
        end
        return r;
    endfunction

    function automatic logic [31:0] rotLeft(input logic [31:0] x, input logic [4:0] n);
        logic [31:0] r;
        r = x;
        for (int k = 0; k < int'(n); k++) begin
            r = {r[30:0], r[31]};
        end
        return r;
    endfunction

    function automatic logic [31:0] makeInstr(input opcodeT op, input logic [3:0] ra,
                                              input logic [3:0] rb, input logic [3:0] rc);
        logic [31:0] w;
        w = '0;
        w[`OPC_MSB:`OPC_LSB] = op;
        w[`RA_MSB:`RA_LSB]   = ra;
        w[`RB_MSB:`RB_LSB]   = rb;
        w[`RC_MSB:`RC_LSB]   = rc;
        return w;
    endfunction

    // Runs the model for one instruction and appends its row.
    task automatic addRow(input opcodeT op, input logic [3:0] ra, input logic [3:0] rb,
                          input logic [3:0] rc, input logic [31:0] data, input logic extra);
        stimRowT     row;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] res;
        logic [31:0] g;
        logic [63:0] prod;
        logic        writes;
        a = modelRegs[rb];
        b = modelRegs[rc];
        res = '0;
        writes = 1'b1;
        row.expLatency = 4'd6;
        case (op)
            opLd: begin
                res = data;
                row.expLatency = 4'd5;
            end
            opAdd: res = a + b;
            opSub: res = a - b;
            opAnd: res = a & b;
            opOr:  res = a | b;
            opShr: res = a >> b[4:0];
            opShl: res = a << b[4:0];
            opRor: res = rotRight(a, b[4:0]);
            opRol: res = rotLeft(a, b[4:0]);
            opMul: begin
                prod = 64'(longint'($signed(a)) * longint'($signed(b)));
                modelHi = prod[63:32];
                modelLo = prod[31:0];
                writes = 1'b0;
                row.expLatency = 4'd7;
            end
            opMfhi: begin
                res = modelHi;
                row.expLatency = 4'd4;
            end
            opMflo: begin
                res = modelLo;
                row.expLatency = 4'd4;
            end
            default: begin
                writes = 1'b0;
                row.expLatency = 4'd4;
            end
        endcase
        if (writes) begin
            modelRegs[ra] = res;
        end
        takeBits(2, g);
        row.instr = makeInstr(op, ra, rb, rc);
        row.data = data;
        row.gap = 8'(g[1:0]) + 8'd1;
        row.extraStart = extra;
        row.expWb.valid = writes;
        row.expWb.index = writes ? ra : 4'd0;
        row.expWb.data = writes ? res : '0;
        stimTable.push_back(row);
    endtask

    task automatic buildTable();
        logic [31:0] d;
        for (int i = 0; i < `NUM_REGS; i++) begin
            modelRegs[i] = '0;
        end
        modelHi = '0;
        modelLo = '0;
        for (int i = 1; i <= 8; i++) begin
            takeBits(32, d);
            addRow(opLd, 4'(i), 4'd0, 4'd0, d, 1'b0);
        end
        addRow(opAdd, 4'd9, 4'd1, 4'd2, '0, 1'b0);
        addRow(opSub, 4'd10, 4'd3, 4'd4, '0, 1'b0);
        addRow(opAnd, 4'd11, 4'd1, 4'd5, '0, 1'b0);
        addRow(opOr, 4'd12, 4'd2, 4'd6, '0, 1'b0);
        // Shift amounts 0 to 31.
        takeBits(5, d);
        addRow(opLd, 4'd13, 4'd0, 4'd0, d, 1'b0);
        takeBits(5, d);
        addRow(opLd, 4'd14, 4'd0, 4'd0, d, 1'b0);
        addRow(opShr, 4'd9, 4'd7, 4'd13, '0, 1'b0);
        addRow(opShl, 4'd10, 4'd7, 4'd14, '0, 1'b0);
        addRow(opRor, 4'd11, 4'd8, 4'd13, '0, 1'b0);
        addRow(opRol, 4'd12, 4'd8, 4'd14, '0, 1'b0);
        addRow(opMul, 4'd0, 4'd1, 4'd2, '0, 1'b0);
        addRow(opMfhi, 4'd3, 4'd0, 4'd0, '0, 1'b0);
        addRow(opMflo, 4'd4, 4'd0, 4'd0, '0, 1'b0);
        // Second start lands while this one is busy.
        addRow(opAdd, 4'd5, 4'd9, 4'd10, '0, 1'b1);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic checkWb(input string name, input wbT got, input wbT exp);
        if (got !== exp) begin
            $display("ERROR %s expected valid=%h index=%h data=%h got valid=%h index=%h data=%h",
                     name, exp.valid, exp.index, exp.data, got.valid, got.index, got.data);
            errors++;
        end
    endtask

    task automatic checkData(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic checkLatency(input int got, input int exp);
        if (got != exp) begin
            $display("ERROR latency expected %h got %h", exp, got);
            errors++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Entered and left on a falling edge.
    task automatic runRow(input int idx, input stimRowT row);
        int     count;
        int     wbSeen;
        int     wbWanted;
        int     startErrors;
        logic   doneSeen;
        opcodeT op;
        startErrors = errors;
        op = opcodeT'(row.instr[`OPC_MSB:`OPC_LSB]);
        wbWanted = row.expWb.valid ? 1 : 0;
        checkFlag("busy", busy, 1'b0);
        start = 1'b1;
        memData = row.instr;
        @(negedge Clock);
        count = 1;
        wbSeen = 0;
        doneSeen = 1'b0;
        while (!doneSeen && count <= 12) begin
            if (count == 2) begin
                checkData("memAddr", memAddr, modelPc);
            end
            if (wb.valid) begin
                wbSeen++;
                checkWb("wb", wb, row.expWb);
            end
            if (done) begin
                doneSeen = 1'b1;
            end else begin
                start = (count == 2) && row.extraStart;
                if (count == 3) begin
                    memData = row.data;
                end
                @(negedge Clock);
                count++;
            end
        end
        modelPc = modelPc + 32'd1;
        if (!doneSeen) begin
            $display("Test %0d never raised done", idx);
            errors++;
        end else begin
            checkLatency(count, int'(row.expLatency));
        end
        if (wbSeen != wbWanted) begin
            $display("Test %0d made %0d register writes instead of %0d", idx, wbSeen, wbWanted);
            errors++;
        end
        for (int g = 0; g < int'(row.gap); g++) begin
            @(negedge Clock);
            start = 1'b0;
            checkFlag("done", done, 1'b0);
            checkFlag("busy", busy, 1'b0);
            checkFlag("wb.valid", wb.valid, 1'b0);
        end
        testsRun++;
        if (errors != startErrors) begin
            testsFailed++;
        end
        $display("Test %0d %s latency %0d: %s", idx, op.name(), count,
                 (errors == startErrors) ? "ok" : "failed");
    endtask

    initial begin
        while (cycleCount <= timeoutLimit) begin
            @(posedge Clock);
            cycleCount++;
        end
        $display("Run stopped at cycle %0d before the tests finished", cycleCount);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int startErrors;
        int total;
        arstN = 1'b0;
        start = 1'b0;
        memData = '0;
        modelPc = '0;
        buildTable();
        total = 60;
        foreach (stimTable[i]) begin
            total += int'(stimTable[i].expLatency) + int'(stimTable[i].gap) + 2;
        end
        timeoutLimit = total;

        repeat (5) @(negedge Clock);
        arstN = 1'b1;
        @(negedge Clock);
        startErrors = errors;
        checkFlag("busy", busy, 1'b0);
        checkFlag("done", done, 1'b0);
        checkFlag("wb.valid", wb.valid, 1'b0);
        checkData("memAddr", memAddr, 32'd0);
        testsRun++;
        if (errors != startErrors) begin
            testsFailed++;
        end
        $display("Test reset: %s", (errors == startErrors) ? "ok" : "failed");

        foreach (stimTable[i]) begin
            runRow(i, stimTable[i]);
        end

        $display("Tests run %0d, failed %0d, check errors %0d", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+.
cpuPkg.sv
regFile.sv
aluUnit.sv
memInterface.sv
pcUnit.sv
controlSequencer.sv
cpuDatapath.sv
cpuTb.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module cpuTb -f tb.f -o cpuSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" sim.log; then
    exit 0
fi
echo "Simulation did not report success"
exit 1
